// ==== verilog/mdio_pkg.sv ====
package mdio_pkg;

  // --------------------------------------------------------------------------
  // management frame codes
  // --------------------------------------------------------------------------

  // clause 22 start of frame
  localparam logic [1:0] mdio_start    = 2'b01;
  localparam logic [1:0] mdio_op_write = 2'b01;
  localparam logic [1:0] mdio_op_read  = 2'b10;

  // ones sent ahead of every frame
  localparam int mdio_preamble_bits = 32;
  // start, op, phy address, register, turnaround and data
  localparam int mdio_frame_bits = 32;

  // --------------------------------------------------------------------------
  // phy registers
  // --------------------------------------------------------------------------

  localparam logic [4:0] reg_basic_ctrl = 5'd0;
  localparam logic [4:0] reg_gbit_ctrl  = 5'd9;
  // indirect mmd access pair
  localparam logic [4:0] reg_mmd_ctrl   = 5'h0d;
  localparam logic [4:0] reg_mmd_data   = 5'h0e;
  // vendor status word
  localparam logic [4:0] reg_phy_status = 5'd31;

  // number of writes in one initialization
  localparam int init_words = 14;

  // fields of the status word
  localparam int status_speed_lsb  = 5;
  localparam int status_speed_msb  = 6;
  localparam int status_duplex_bit = 3;

endpackage

// ==== verilog/phy_init_sequencer.sv ====
`timescale 1ns/1ps

module phy_init_sequencer (
  input  logic        clock,
  input  logic        arst_n,
  input  logic        init_request,
  input  logic        allow_1gbit,
  input  logic        ready,
  output logic        rd_request,
  output logic        wr_request,
  output logic [4:0]  reg_addr,
  output logic [15:0] wr_data,
  output logic        init_active
);

  import mdio_pkg::*;

  // index of the next table word to write, runs up to init_words
  logic [3:0]  word_no;
  logic        last_allow;
  logic        pending;
  logic        slot;
  logic        start;
  logic        trigger;
  logic [4:0]  tbl_addr;
  logic [15:0] tbl_data;

  // --------------------------------------------------------------------------
  // init table
  // --------------------------------------------------------------------------

  // each mmd write is ctrl=dev, data=reg, ctrl=dev|no-increment, data=value
  always_comb
  begin
    tbl_addr = reg_phy_status;
    tbl_data = 16'h0000;
    case (word_no)
      4'd0:  begin tbl_addr = reg_gbit_ctrl;  tbl_data = {6'b0, last_allow, 9'b0}; end
      4'd1:  begin tbl_addr = reg_mmd_ctrl;   tbl_data = 16'h0002; end
      4'd2:  begin tbl_addr = reg_mmd_data;   tbl_data = 16'h0004; end
      4'd3:  begin tbl_addr = reg_mmd_ctrl;   tbl_data = 16'h4002; end
      4'd4:  begin tbl_addr = reg_mmd_data;   tbl_data = 16'h0007; end
      4'd5:  begin tbl_addr = reg_mmd_ctrl;   tbl_data = 16'h0002; end
      4'd6:  begin tbl_addr = reg_mmd_data;   tbl_data = 16'h0005; end
      4'd7:  begin tbl_addr = reg_mmd_ctrl;   tbl_data = 16'h4002; end
      4'd8:  begin tbl_addr = reg_mmd_data;   tbl_data = 16'h0000; end
      4'd9:  begin tbl_addr = reg_mmd_ctrl;   tbl_data = 16'h0002; end
      4'd10: begin tbl_addr = reg_mmd_data;   tbl_data = 16'h0008; end
      4'd11: begin tbl_addr = reg_mmd_ctrl;   tbl_data = 16'h4002; end
      4'd12: begin tbl_addr = reg_mmd_data;   tbl_data = 16'h01f8; end
      // restart auto-negotiation last
      4'd13: begin tbl_addr = reg_basic_ctrl; tbl_data = 16'h1300; end
      default: ;
    endcase
  end

  // --------------------------------------------------------------------------
  // request scheduling
  // --------------------------------------------------------------------------

  // master idle and no request of ours still in its accept cycle
  assign slot = ready & ~rd_request & ~wr_request;
  // a new init begins only once every table word has gone out
  assign start = slot & pending & ~(init_active & (word_no < 4'(init_words)));
  // the allow compare is stale in the cycle that latches it
  assign trigger = init_request | (~start & (allow_1gbit != last_allow));

  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      rd_request  <= 1'b0;
      wr_request  <= 1'b0;
      init_active <= 1'b0;
      pending     <= 1'b0;
      word_no     <= 4'd0;
      // mismatch on purpose so the first init runs by itself
      last_allow  <= ~allow_1gbit;
    end
    else
    begin
      rd_request <= 1'b0;
      wr_request <= 1'b0;
      pending    <= (pending & ~start) | trigger;
      if (slot)
      begin
        if (init_active && word_no < 4'(init_words))
        begin
          wr_request <= 1'b1;
          word_no    <= word_no + 4'd1;
        end
        else if (pending)
        begin
          // spend this slot latching, word 0 goes out next cycle
          init_active <= 1'b1;
          last_allow  <= allow_1gbit;
          word_no     <= 4'd0;
        end
        else
        begin
          init_active <= 1'b0;
          rd_request  <= 1'b1;
        end
      end
    end
  end

  // payload follows the request, no reset needed
  always_ff @(posedge clock)
  begin
    if (slot)
    begin
      reg_addr <= (init_active && word_no < 4'(init_words)) ? tbl_addr : reg_phy_status;
      wr_data  <= tbl_data;
    end
  end

endmodule

// ==== verilog/mdio_master.sv ====
`timescale 1ns/1ps

module mdio_master #(
  // clock cycles per mdc half period, 2 or more
  parameter int unsigned mdc_half_period = 10,
  parameter logic [4:0]  phy_addr        = 5'd0
) (
  input  logic        clock,
  input  logic        arst_n,
  input  logic        rd_request,
  input  logic        wr_request,
  input  logic [4:0]  reg_addr,
  input  logic [15:0] wr_data,
  input  logic        mdio_in,
  output logic        ready,
  output logic [15:0] rd_data,
  output logic        rd_valid,
  output logic        mdc,
  output logic        mdio_out,
  output logic        mdio_oe
);

  import mdio_pkg::*;

  // 64 bits per transaction, two mdc halves each
  localparam int frame_total = mdio_preamble_bits + mdio_frame_bits;
  localparam int half_total  = 2 * frame_total;
  localparam int div_w       = $clog2(mdc_half_period + 1);
  localparam int half_w      = $clog2(half_total);
  localparam int bit_w       = $clog2(frame_total);
  // first turnaround bit and first data bit, counted from preamble start
  localparam int ta_bit      = mdio_preamble_bits + 14;
  localparam int data_bit    = ta_bit + 2;

  logic                   busy;
  logic                   is_read;
  logic [div_w-1:0]       div_cnt;
  logic [half_w-1:0]      half_cnt;
  logic [bit_w-1:0]       bit_cnt;
  logic [frame_total-1:0] tx_shift;
  logic [frame_total-1:0] tx_frame;
  logic [15:0]            rx_shift;
  logic                   accept;
  logic                   half_end;
  logic                   last_half;

  assign ready     = ~busy;
  assign accept    = ~busy & (rd_request | wr_request);
  assign half_end  = busy & (div_cnt == div_w'(mdc_half_period - 1));
  assign last_half = (half_cnt == half_w'(half_total - 1));
  assign mdio_out  = tx_shift[frame_total-1];

  // --------------------------------------------------------------------------
  // frame assembly
  // --------------------------------------------------------------------------

  // read frames carry ones after the register field, the pin is released there
  always_comb
  begin
    if (wr_request)
      tx_frame = {{mdio_preamble_bits{1'b1}}, mdio_start, mdio_op_write,
                  phy_addr, reg_addr, 2'b10, wr_data};
    else
      tx_frame = {{mdio_preamble_bits{1'b1}}, mdio_start, mdio_op_read,
                  phy_addr, reg_addr, 2'b11, 16'hffff};
  end

  // --------------------------------------------------------------------------
  // mdc divider and bit sequencing
  // --------------------------------------------------------------------------

  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      busy     <= 1'b0;
      is_read  <= 1'b0;
      div_cnt  <= '0;
      half_cnt <= '0;
      bit_cnt  <= '0;
      mdc      <= 1'b0;
      mdio_oe  <= 1'b0;
      rd_valid <= 1'b0;
    end
    else
    begin
      rd_valid <= 1'b0;
      if (accept)
      begin
        busy     <= 1'b1;
        is_read  <= ~wr_request;
        // accept cycle counts as the first cycle of half 0
        div_cnt  <= div_w'(1);
        half_cnt <= '0;
        bit_cnt  <= '0;
        mdio_oe  <= 1'b1;
      end
      else if (busy)
      begin
        if (half_end)
        begin
          div_cnt <= '0;
          mdc     <= ~mdc;
          if (last_half)
          begin
            // final falling edge, ready and rd_valid rise together
            busy     <= 1'b0;
            mdio_oe  <= 1'b0;
            rd_valid <= is_read;
          end
          else
          begin
            half_cnt <= half_cnt + 1'b1;
            // falling edge moves on to the next bit
            if (mdc)
            begin
              bit_cnt <= bit_cnt + 1'b1;
              if (is_read && bit_cnt == bit_w'(ta_bit - 1))
                mdio_oe <= 1'b0;
            end
          end
        end
        else
        begin
          div_cnt <= div_cnt + 1'b1;
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // shift registers
  // --------------------------------------------------------------------------

  always_ff @(posedge clock)
  begin
    if (accept)
      tx_shift <= tx_frame;
    else if (half_end && mdc && !last_half)
      tx_shift <= {tx_shift[frame_total-2:0], 1'b1};

    // phy drives data after its falling edge, we sample on the rising one
    if (half_end && !mdc && is_read && bit_cnt >= bit_w'(data_bit))
      rx_shift <= {rx_shift[14:0], mdio_in};

    if (half_end && last_half)
      rd_data <= rx_shift;
  end

endmodule

// ==== verilog/phy_status_decoder.sv ====
`timescale 1ns/1ps

module phy_status_decoder (
  input  logic        clock,
  input  logic        arst_n,
  input  logic        rd_valid,
  input  logic [15:0] rd_data,
  input  logic        init_active,
  output logic [1:0]  speed,
  output logic        duplex
);

  import mdio_pkg::*;

  logic good_read;

  // --------------------------------------------------------------------------
  // read qualification
  // --------------------------------------------------------------------------

  // all ones means the pullup won, no phy drove the bus
  // status read while the phy is being reconfigured is not trusted
  assign good_read = rd_valid & ~init_active & (rd_data != 16'hffff);

  // last good values held until the next good read
  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
    begin
      speed  <= 2'b00;
      duplex <= 1'b0;
    end
    else if (good_read)
    begin
      speed  <= rd_data[status_speed_msb:status_speed_lsb];
      duplex <= rd_data[status_duplex_bit];
    end
  end

endmodule

// ==== verilog/phy_manager.sv ====
`timescale 1ns/1ps

module phy_manager #(
  parameter int unsigned mdc_half_period = 10,
  parameter logic [4:0]  phy_addr        = 5'd0
) (
  input  logic       clock,
  input  logic       arst_n,
  input  logic       init_request,
  input  logic       allow_1gbit,
  output logic [1:0] speed,
  output logic       duplex,
  output logic       mdc,
  inout  wire        mdio
);

  logic        rd_request;
  logic        wr_request;
  logic [4:0]  reg_addr;
  logic [15:0] wr_data;
  logic        ready;
  logic [15:0] rd_data;
  logic        rd_valid;
  logic        init_active;
  logic        mdio_out;
  logic        mdio_oe;
  logic        mdio_in;

  // --------------------------------------------------------------------------
  // mdio pad
  // --------------------------------------------------------------------------

  // open when released, board pullup gives ones
  assign mdio    = mdio_oe ? mdio_out : 1'bz;
  assign mdio_in = mdio;

  // decides what goes on the bus next
  phy_init_sequencer u_sequencer (
    .clock        (clock),
    .arst_n       (arst_n),
    .init_request (init_request),
    .allow_1gbit  (allow_1gbit),
    .ready        (ready),
    .rd_request   (rd_request),
    .wr_request   (wr_request),
    .reg_addr     (reg_addr),
    .wr_data      (wr_data),
    .init_active  (init_active)
  );

  mdio_master #(
    .mdc_half_period (mdc_half_period),
    .phy_addr        (phy_addr)
  ) u_master (
    .clock      (clock),
    .arst_n     (arst_n),
    .rd_request (rd_request),
    .wr_request (wr_request),
    .reg_addr   (reg_addr),
    .wr_data    (wr_data),
    .mdio_in    (mdio_in),
    .ready      (ready),
    .rd_data    (rd_data),
    .rd_valid   (rd_valid),
    .mdc        (mdc),
    .mdio_out   (mdio_out),
    .mdio_oe    (mdio_oe)
  );

  phy_status_decoder u_decoder (
    .clock       (clock),
    .arst_n      (arst_n),
    .rd_valid    (rd_valid),
    .rd_data     (rd_data),
    .init_active (init_active),
    .speed       (speed),
    .duplex      (duplex)
  );

endmodule

// ==== test/mdio_phy_model.sv ====
`timescale 1ns/1ps

module mdio_phy_model #(
  parameter logic [4:0] phy_addr = 5'd3
) (
  input  logic        mdc,
  inout  wire         mdio,
  input  logic [15:0] status_word,
  input  logic        answer_enable,
  output logic [4:0]  wr_reg,
  output logic [15:0] wr_value,
  output int          wr_count,
  output int          rd_count,
  output int          frame_errors
);

  int          ones_cnt;
  int          bit_no;
  logic        in_frame;
  logic        is_read;
  logic        read_done;
  // start, op, phy address and register, first bit in the top position
  logic [13:0] header;
  logic [15:0] data_in;
  logic [15:0] reply;
  logic        drive_en;
  logic        drive_bit;

  assign mdio = drive_en ? drive_bit : 1'bz;

  initial
  begin
    ones_cnt     = 0;
    bit_no       = 0;
    in_frame     = 1'b0;
    is_read      = 1'b0;
    read_done    = 1'b0;
    header       = '0;
    data_in      = '0;
    reply        = '0;
    drive_en     = 1'b0;
    drive_bit    = 1'b1;
    wr_reg       = '0;
    wr_value     = '0;
    wr_count     = 0;
    rd_count     = 0;
    frame_errors = 0;
  end

  // --------------------------------------------------------------------------
  // frame header checks
  // --------------------------------------------------------------------------

  task automatic check_header;
    if (header[13:12] != 2'b01)
    begin
      $display("CHECK FAILED at %0t: start code %b, expected 01", $time, header[13:12]);
      frame_errors = frame_errors + 1;
    end
    if (header[9:5] != phy_addr)
    begin
      $display("CHECK FAILED at %0t: phy address %0d, expected %0d",
               $time, header[9:5], phy_addr);
      frame_errors = frame_errors + 1;
    end
    is_read = (header[11:10] == 2'b10);
    // only status register 31 may be polled
    if (is_read && header[4:0] != 5'd31)
    begin
      $display("CHECK FAILED at %0t: read of register %0d, expected 31", $time, header[4:0]);
      frame_errors = frame_errors + 1;
    end
    if (header[11:10] != 2'b10 && header[11:10] != 2'b01)
    begin
      $display("CHECK FAILED at %0t: op code %b is neither read nor write",
               $time, header[11:10]);
      frame_errors = frame_errors + 1;
    end
  endtask

  // --------------------------------------------------------------------------
  // receive side, sampled on the rising edge
  // --------------------------------------------------------------------------

  always @(posedge mdc)
  begin
    if (!in_frame)
    begin
      // a zero after a full preamble is the first start bit
      if (mdio === 1'b0 && ones_cnt >= 32)
      begin
        in_frame = 1'b1;
        bit_no   = 0;
        header   = '0;
      end
      else if (mdio === 1'b1)
        ones_cnt = ones_cnt + 1;
      else
        ones_cnt = 0;
    end
    else
    begin
      bit_no = bit_no + 1;
      if (bit_no < 14)
        header = {header[12:0], mdio};
      else if (bit_no >= 16)
        data_in = {data_in[14:0], mdio};
      if (bit_no == 13)
        check_header();
      if (bit_no == 31)
      begin
        in_frame = 1'b0;
        ones_cnt = 0;
        if (is_read)
          read_done = 1'b1;
        else
        begin
          wr_reg   = header[4:0];
          wr_value = data_in;
          wr_count = wr_count + 1;
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // read answer, driven after the falling edge
  // --------------------------------------------------------------------------

  always @(negedge mdc)
  begin
    if (read_done)
    begin
      // last falling edge of the frame, bus goes back to the master
      drive_en  = 1'b0;
      read_done = 1'b0;
      rd_count  = rd_count + 1;
    end
    else if (in_frame && is_read && bit_no >= 14)
    begin
      if (bit_no == 14)
      begin
        // second turnaround bit is a driven zero
        reply     = status_word;
        drive_bit = 1'b0;
        drive_en  = answer_enable;
      end
      else
        drive_bit = reply[30 - bit_no];
    end
  end

endmodule

// ==== test/phy_manager_tb.sv ====
`timescale 1ns/1ps

module phy_manager_tb;

  import mdio_pkg::*;

  // about 60 transactions of 256 cycles each, with margin
  localparam int max_cycles = 40000;

  logic        clock;
  logic        arst_n;
  logic        init_request;
  logic        allow_1gbit;
  logic [1:0]  speed;
  logic        duplex;
  logic        mdc;
  wire         mdio;

  logic [15:0] status_word;
  logic        answer_enable;
  logic [4:0]  wr_reg;
  logic [15:0] wr_value;
  int          wr_count;
  int          rd_count;
  int          frame_errors;

  int          seed;
  int          errors;
  int          cycles;
  int          writes_seen;
  // writes still owed by the running init, and where in the table it is
  int          expect_left;
  int          word_index;
  logic        expect_allow;
  logic [20:0] exp_word;
  logic [15:0] rnd;
  logic [1:0]  held_speed;
  logic        held_duplex;

  // released bus reads as ones
  pullup (mdio);

  phy_manager #(
    .mdc_half_period (2),
    .phy_addr        (5'd3)
  ) dut (
    .clock        (clock),
    .arst_n       (arst_n),
    .init_request (init_request),
    .allow_1gbit  (allow_1gbit),
    .speed        (speed),
    .duplex       (duplex),
    .mdc          (mdc),
    .mdio         (mdio)
  );

  mdio_phy_model #(
    .phy_addr (5'd3)
  ) phy (
    .mdc           (mdc),
    .mdio          (mdio),
    .status_word   (status_word),
    .answer_enable (answer_enable),
    .wr_reg        (wr_reg),
    .wr_value      (wr_value),
    .wr_count      (wr_count),
    .rd_count      (rd_count),
    .frame_errors  (frame_errors)
  );

  initial
  begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // --------------------------------------------------------------------------
  // reference model of the init table
  // --------------------------------------------------------------------------

  // returns {register, value} for one table word
  function automatic logic [20:0] expected_write(input int index, input logic allow);
    logic [4:0]  r;
    logic [15:0] v;
    int          k;
    r = 5'd0;
    v = 16'h1300;
    k = (index - 1) / 4;
    if (index == 0)
    begin
      r    = 5'd9;
      v    = 16'h0000;
      v[9] = allow;
    end
    else if (index < 13)
    begin
      // indirect mmd write, four words each, ctrl and data alternate
      r = ((index - 1) % 2 == 0) ? 5'h0d : 5'h0e;
      case ((index - 1) % 4)
        0:       v = 16'h0002;
        1:       v = (k == 0) ? 16'h0004 : (k == 1) ? 16'h0005 : 16'h0008;
        2:       v = 16'h4002;
        default: v = (k == 0) ? 16'h0007 : (k == 1) ? 16'h0000 : 16'h01f8;
      endcase
    end
    return {r, v};
  endfunction

  // --------------------------------------------------------------------------
  // write checker and run limit
  // --------------------------------------------------------------------------

  always @(posedge clock)
  begin
    if (wr_count != writes_seen)
    begin
      writes_seen = writes_seen + 1;
      if (expect_left == 0)
      begin
        $display("ERROR at %0t: the PHY got a write to register %0d (%h) outside an init",
                 $time, wr_reg, wr_value);
        errors = errors + 1;
      end
      else
      begin
        exp_word = expected_write(word_index, expect_allow);
        if (wr_reg !== exp_word[20:16] || wr_value !== exp_word[15:0])
        begin
          $display("CHECK FAILED at %0t: write %0d is reg %0d data %h, expected reg %0d data %h",
                   $time, word_index, wr_reg, wr_value, exp_word[20:16], exp_word[15:0]);
          errors = errors + 1;
        end
        word_index  = word_index + 1;
        expect_left = expect_left - 1;
      end
    end
  end

  always @(posedge clock)
  begin
    cycles = cycles + 1;
    if (cycles >= max_cycles)
    begin
      $display("ERROR: the run did not finish within %0d cycles", max_cycles);
      $display("errors: %0d checks, %0d frames", errors, frame_errors);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------

  task automatic wait_init_done;
    while (expect_left > 0)
      @(posedge clock);
  endtask

  // the first read may have started before a change, the second cannot
  task automatic wait_reads(input int n);
    int target;
    target = rd_count + n;
    while (rd_count < target)
      @(posedge clock);
    // decoder registers one cycle after rd_valid
    @(posedge clock);
    @(negedge clock);
  endtask

  task automatic check_status(input logic [1:0] exp_speed, input logic exp_duplex);
    if (speed !== exp_speed)
    begin
      $display("CHECK FAILED at %0t: speed %b, expected %b", $time, speed, exp_speed);
      errors = errors + 1;
    end
    if (duplex !== exp_duplex)
    begin
      $display("CHECK FAILED at %0t: duplex %b, expected %b", $time, duplex, exp_duplex);
      errors = errors + 1;
    end
  endtask

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------

  initial
  begin
    seed          = 32'hde92e783;
    errors        = 0;
    cycles        = 0;
    writes_seen   = 0;
    arst_n        = 1'b0;
    init_request  = 1'b0;
    allow_1gbit   = 1'b1;
    status_word   = 16'h0000;
    answer_enable = 1'b1;
    // reset init runs by itself with the current allow setting
    expect_allow  = 1'b1;
    expect_left   = init_words;
    word_index    = 0;
    repeat (10) @(posedge clock);
    arst_n <= 1'b1;
    @(negedge clock);
    check_status(2'b00, 1'b0);

    wait_init_done();
    wait_reads(2);

    // status words from the model show up on the ports
    repeat (4)
    begin
      @(posedge clock);
      rnd = $random(seed);
      // all ones would read as no phy
      rnd[15] = 1'b0;
      status_word <= rnd;
      wait_reads(2);
      check_status(rnd[6:5], rnd[3]);
    end

    // allow change gives a fresh init with the new reg 9 value
    @(posedge clock);
    expect_allow = ~allow_1gbit;
    expect_left  = init_words;
    word_index   = 0;
    allow_1gbit <= ~allow_1gbit;
    wait_init_done();
    wait_reads(2);

    // one pulse, one more init, reg 9 unchanged
    @(posedge clock);
    expect_left = init_words;
    word_index  = 0;
    init_request <= 1'b1;
    @(posedge clock);
    init_request <= 1'b0;
    wait_init_done();
    wait_reads(2);

    // known good word whose fields all differ from an all ones read
    @(posedge clock);
    status_word <= 16'h0020;
    wait_reads(2);
    check_status(2'b01, 1'b0);

    // undriven bus reads all ones, old values stay
    held_speed  = status_word[6:5];
    held_duplex = status_word[3];
    @(posedge clock);
    answer_enable <= 1'b0;
    wait_reads(2);
    check_status(held_speed, held_duplex);

    $display("errors: %0d checks, %0d frames", errors, frame_errors);
    if (errors == 0 && frame_errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== files.f ====
verilog/mdio_pkg.sv
verilog/phy_init_sequencer.sv
verilog/mdio_master.sv
verilog/phy_status_decoder.sv
verilog/phy_manager.sv
test/mdio_phy_model.sv
test/phy_manager_tb.sv
